/* flist.f */
src/lcd_pkg.sv
src/serial_master.sv
src/text_ram.sv
src/txtlcd_3wire.sv
src/lcd_text_top.sv
tb/lcd_bus_asserts.sv
tb/tb_lcd_text.sv

/* Makefile */
TOP = tb_lcd_text

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench, result from sim.log"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

obj_dir/V$(TOP): flist.f $(shell cat flist.f)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f flist.f

test: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1; status=$$?; cat sim.log; \
	if grep -q "Testbench failed" sim.log; then \
		echo "simulation reported a failure"; exit 1; \
	fi; \
	if [ $$status -ne 0 ]; then \
		echo "simulator exited with status $$status"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

/* tb/tb_lcd_text.sv */
// self-checking testbench for the text lcd driver, a behavioral lcd answers on the 3-wire bus
module tb_lcd_text;
	timeunit 1ns;
	timeprecision 100ps;
	import lcd_pkg::*;

	// worst case redraw with three busy answers per write, in clocks
	localparam int redraw_limit = 300_000;

	typedef logic [8:0] frame_q_t [$];

	logic                 clk = 1'b0;
	logic                 rst_n;
	logic                 update;
	logic                 wr_en;
	logic [addr_bits-1:0] wr_addr;
	logic [7:0]           wr_data;
	logic                 scl;
	logic                 sda_o;
	logic                 sda_i = 1'b0;
	logic                 lcd_rst;
	logic                 busy;

	integer seed = 32'hac5;

	logic [7:0] image1 [lcd_size];
	logic [7:0] image2 [lcd_size];

	// writes as {rs, byte}
	frame_q_t   exp_q;
	frame_q_t   got_q;
	logic [8:0] got_w;
	logic [8:0] exp_w;

	// lcd model
	logic       scl_q;
	logic [7:0] rx_byte;
	int         bit_n;
	int         byte_n;
	logic       fr_rw;
	logic       fr_rs;
	logic [3:0] lo_nib;
	logic [7:0] status;
	int         busy_target;
	int         polls_left;
	int         reads_seen;

	lcd_text_top u_dut (
		.clk27        (clk),
		.rst_n        (rst_n),
		.update       (update),
		.wr_en        (wr_en),
		.wr_addr      (wr_addr),
		.wr_data      (wr_data),
		.txtlcd_scl   (scl),
		.txtlcd_sda_o (sda_o),
		.txtlcd_sda_i (sda_i),
		.txtlcd_rst   (lcd_rst),
		.busy         (busy)
	);

	bind lcd_text_top lcd_bus_asserts u_bus_asserts (
		.clk27     (clk27),
		.rst_n     (rst_n),
		.enable    (serial_enable),
		.ready     (serial_ready),
		.next_word (serial_next),
		.data_out  (serial_data_out),
		.busy      (busy)
	);

	// 125 MHz
	always #4 clk = ~clk;

	// ------------------------------
	// checks
	// ------------------------------
	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("Testbench failed");
		$fatal(1);
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			stop_run($sformatf("Fail at %0d ns: %s, got %b expected %b", $time, what, got, exp));
		end
	endtask

	task automatic check_count(input int got, input int exp, input string what);
		if (got != exp) begin
			stop_run($sformatf("Fail at %0d ns: %s, got %0d expected %0d", $time, what, got, exp));
		end
	endtask

	task automatic check_cmd(input logic rs, input logic [7:0] got, input logic [7:0] exp);
		check_bit(rs, 1'b0, "register select of a command");
		if (got !== exp) begin
			stop_run($sformatf("Fail at %0d ns: command %h expected %h", $time, got, exp));
		end
	endtask

	task automatic check_char(input logic rs, input logic [7:0] got, input logic [7:0] exp);
		check_bit(rs, 1'b1, "register select of a character");
		if (got !== exp) begin
			stop_run($sformatf("Fail at %0d ns: character %h expected %h", $time, got, exp));
		end
	endtask

	// ------------------------------
	// reference model
	// ------------------------------
	// init list, then per row its ddram address and its twenty characters
	function automatic frame_q_t expected_frames(input logic [7:0] img [lcd_size]);
		frame_q_t q;
		for (int k = 0; k < init_len; k++) begin
			q.push_back({1'b0, init_cmds[k]});
		end
		for (int r = 0; r < lcd_rows; r++) begin
			q.push_back({1'b0, cmd_set_ddram | line_addr[r]});
			for (int c = 0; c < lcd_cols; c++) begin
				q.push_back({1'b1, img[r * lcd_cols + c]});
			end
		end
		return q;
	endfunction

	// ------------------------------
	// behavioral lcd
	// ------------------------------
	task automatic take_byte(input logic [7:0] b);
		if (byte_n == 0) begin
			// start byte, low bit first: sync ones, rw, rs, zero
			check_bit(&b[4:0], 1'b1, "sync ones of a start byte");
			check_bit(b[7], 1'b0, "last bit of a start byte");
			fr_rw  = b[5];
			fr_rs  = b[6];
			byte_n = 1;
			if (fr_rw) begin
				check_bit(fr_rs, 1'b0, "register select of a busy read");
				reads_seen++;
				status = (polls_left > 0) ? 8'h80 : 8'h00;
				if (polls_left > 0) begin
					polls_left--;
				end
			end
		end else if (fr_rw) begin
			// read word done
			byte_n = 0;
			fr_rw  = 1'b0;
		end else if (byte_n == 1) begin
			check_bit(|b[7:4], 1'b0, "upper bits of the low nibble byte");
			lo_nib = b[3:0];
			byte_n = 2;
		end else begin
			check_bit(|b[7:4], 1'b0, "upper bits of the high nibble byte");
			got_q.push_back({fr_rs, b[3:0], lo_nib});
			check_count(reads_seen, busy_target + 1, "busy reads before a write");
			// busy answers for the next write
			busy_target = $unsigned($random(seed)) % 4;
			polls_left  = busy_target;
			reads_seen  = 0;
			byte_n      = 0;
		end
	endtask

	// scl edges seen one clock late, sda_i moves long before the next rising edge
	always @(posedge clk) begin
		if (!rst_n) begin
			scl_q       = 1'b1;
			bit_n       = 0;
			byte_n      = 0;
			fr_rw       = 1'b0;
			fr_rs       = 1'b0;
			reads_seen  = 0;
			busy_target = $unsigned($random(seed)) % 4;
			polls_left  = busy_target;
			sda_i      <= 1'b0;
		end else begin
			if (scl && !scl_q) begin
				rx_byte = {sda_o, rx_byte[7:1]};
				bit_n   = bit_n + 1;
				if (bit_n == bus_bits) begin
					bit_n = 0;
					take_byte(rx_byte);
				end
				// status goes out low bit first during the read word
				if (fr_rw && byte_n == 1) begin
					sda_i <= status[bit_n];
				end else begin
					sda_i <= 1'b0;
				end
			end
			scl_q = scl;
		end
	end

	// decoded writes against the reference list
	always @(posedge clk) begin
		if (got_q.size() != 0) begin
			got_w = got_q.pop_front();
			if (exp_q.size() == 0) begin
				stop_run($sformatf("unexpected write %h after the expected list ended", got_w));
			end
			exp_w = exp_q.pop_front();
			if (!exp_w[8]) begin
				check_cmd(got_w[8], got_w[7:0], exp_w[7:0]);
			end else begin
				check_char(got_w[8], got_w[7:0], exp_w[7:0]);
			end
		end
	end

	// ------------------------------
	// stimulus helpers
	// ------------------------------
	task automatic load_image(input logic [7:0] img [lcd_size]);
		for (int a = 0; a < lcd_size; a++) begin
			@(posedge clk);
			wr_en   <= 1'b1;
			wr_addr <= addr_bits'(a);
			wr_data <= img[a];
		end
		@(posedge clk);
		wr_en <= 1'b0;
	endtask

	task automatic pulse_update();
		@(posedge clk);
		update <= 1'b1;
		@(posedge clk);
		update <= 1'b0;
	endtask

	// lcd reset low and bus quiet for the whole hold time
	task automatic check_hold();
		for (int n = 0; n < reset_hold_cycles; n++) begin
			@(negedge clk);
			check_bit(lcd_rst, 1'b0, "lcd reset during the hold time");
			check_bit(scl, 1'b1, "bus clock idle during the hold time");
		end
	endtask

	task automatic wait_lcd_rst();
		int n;
		n = 0;
		@(negedge clk);
		while (lcd_rst !== 1'b1) begin
			if (n >= 4) begin
				stop_run("timeout waiting for the lcd reset to be released");
			end
			@(negedge clk);
			n++;
		end
	endtask

	task automatic wait_busy(input logic level, input int limit, input string what);
		int n;
		n = 0;
		@(negedge clk);
		while (busy !== level) begin
			if (n >= limit) begin
				stop_run($sformatf("timeout waiting for the %s", what));
			end
			@(negedge clk);
			n++;
		end
	endtask

	task automatic wait_drain(input string what);
		int n;
		n = 0;
		while (got_q.size() != 0) begin
			if (n >= 100) begin
				stop_run($sformatf("timeout waiting for the last write of the %s", what));
			end
			@(negedge clk);
			n++;
		end
		if (exp_q.size() != 0) begin
			stop_run($sformatf("the %s ended with %0d writes missing", what, exp_q.size()));
		end
	endtask

	// ------------------------------
	// main sequence
	// ------------------------------
	initial begin
		rst_n   = 1'b0;
		update  = 1'b0;
		wr_en   = 1'b0;
		wr_addr = '0;
		wr_data = '0;
		// random printable text, then a pattern over the whole address
		for (int a = 0; a < lcd_size; a++) begin
			image1[a] = 8'h20 + 8'($unsigned($random(seed)) % 95);
			image2[a] = 8'h30 + 8'(a);
		end
		exp_q = expected_frames(image1);

		for (int n = 0; n < 10; n++) begin
			@(negedge clk);
			check_bit(lcd_rst, 1'b0, "lcd reset while in reset");
			check_bit(busy, 1'b1, "busy while in reset");
			check_bit(scl, 1'b1, "bus clock while in reset");
			check_bit(sda_o, 1'b0, "bus data while in reset");
		end
		@(posedge clk);
		rst_n <= 1'b1;

		// text goes in while the display is still held in reset
		fork
			load_image(image1);
			check_hold();
		join
		wait_lcd_rst();
		wait_busy(1'b0, redraw_limit, "end of the first redraw");
		wait_drain("first redraw");

		// new text, then an extra update in the middle of the redraw
		load_image(image2);
		exp_q = expected_frames(image2);
		pulse_update();
		wait_busy(1'b1, 10, "start of the second redraw");
		for (int n = 0; n < 1000; n++) begin
			@(negedge clk);
		end
		check_bit(busy, 1'b1, "busy before the extra update");
		pulse_update();
		wait_busy(1'b0, redraw_limit, "end of the second redraw");
		wait_drain("second redraw");

		// ignored update leaves the display idle
		for (int n = 0; n < 4000; n++) begin
			@(negedge clk);
			check_bit(busy, 1'b0, "busy after the second redraw");
		end

		$display("Testbench passed");
		$finish;
	end

endmodule

/* tb/lcd_bus_asserts.sv */
// bound checks on the serial handshake and the busy output, attached to the top level by bind
module lcd_bus_asserts (
	input logic                         clk27,
	input logic                         rst_n,
	input logic                         enable,
	input logic                         ready,
	input logic                         next_word,
	input logic [lcd_pkg::bus_bits-1:0] data_out,
	input logic                         busy
);
	timeunit 1ns;
	timeprecision 100ps;
	import lcd_pkg::*;

	// init list plus one address and twenty characters per row
	localparam int redraw_writes = init_len + lcd_rows * (lcd_cols + 1);

	// write bursts since reset, saturates once the first redraw is out
	int writes;

	// burst start is enable seen while the engine is still idle, bit 5 is rw
	always_ff @(posedge clk27 or negedge rst_n) begin
		if (!rst_n) begin
			writes <= 0;
		end else if (enable && ready && !data_out[5] && writes < redraw_writes) begin
			writes <= writes + 1;
		end
	end

	// ------------------------------
	// handshake
	// ------------------------------
	// word and enable only move right after next_word
	assert property (@(posedge clk27) disable iff (!rst_n)
		(!ready && !$past(next_word)) |-> $stable({enable, data_out}))
		else $error("bus word or enable changed in the middle of a word");

	assert property (@(posedge clk27) disable iff (!rst_n)
		next_word |=> !next_word)
		else $error("next_word held for more than one clock");

	// ------------------------------
	// busy
	// ------------------------------
	assert property (@(posedge clk27) disable iff (!rst_n)
		(writes < redraw_writes) |-> busy)
		else $error("busy dropped before the first redraw was written");

endmodule

/* src/lcd_text_top.sv */
// top level of the text lcd driver, text memory, controller and serial engine on the lcd pins
module lcd_text_top (
	input  logic                          clk27,
	input  logic                          rst_n,
	input  logic                          update,
	input  logic                          wr_en,
	input  logic [lcd_pkg::addr_bits-1:0] wr_addr,
	input  logic [7:0]                    wr_data,
	output logic                          txtlcd_scl,
	output logic                          txtlcd_sda_o,
	input  logic                          txtlcd_sda_i,
	output logic                          txtlcd_rst,
	output logic                          busy
);
	import lcd_pkg::*;

	// ------------------------------
	// internal wiring
	// ------------------------------
	// serial handshake
	logic                serial_enable;
	logic                serial_ready;
	logic                serial_next;
	logic [bus_bits-1:0] serial_data_out;
	logic [bus_bits-1:0] serial_data_in;

	// text memory read side
	logic [addr_bits-1:0] ram_addr;
	logic [7:0]           ram_data;

	text_ram u_ram (
		.clk27   (clk27),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.rd_addr (ram_addr),
		.rd_data (ram_data)
	);

	txtlcd_3wire u_lcd (
		.clk27        (clk27),
		.rst_n        (rst_n),
		.update       (update),
		.bus_data_in  (serial_data_in),
		.bus_next     (serial_next),
		.bus_ready    (serial_ready),
		.bus_data_out (serial_data_out),
		.bus_enable   (serial_enable),
		.mem_word     (ram_data),
		.mem_addr     (ram_addr),
		.busy         (busy),
		.lcd_rst      (txtlcd_rst)
	);

	// one bus, low bit first
	serial_master u_serial (
		.clk27     (clk27),
		.rst_n     (rst_n),
		.enable    (serial_enable),
		.data_out  (serial_data_out),
		.ready     (serial_ready),
		.next_word (serial_next),
		.data_in   (serial_data_in),
		.scl       (txtlcd_scl),
		.sda_o     (txtlcd_sda_o),
		.sda_i     (txtlcd_sda_i)
	);

endmodule

/* src/txtlcd_3wire.sv */
// lcd protocol controller, runs reset hold, busy polls, init list and text redraw over the bus
module txtlcd_3wire (
	input  logic                          clk27,
	input  logic                          rst_n,
	input  logic                          update,
	input  logic [lcd_pkg::bus_bits-1:0]  bus_data_in,
	input  logic                          bus_next,
	input  logic                          bus_ready,
	output logic [lcd_pkg::bus_bits-1:0]  bus_data_out,
	output logic                          bus_enable,
	input  logic [7:0]                    mem_word,
	output logic [lcd_pkg::addr_bits-1:0] mem_addr,
	output logic                          busy,
	output logic                          lcd_rst
);
	import lcd_pkg::*;

	localparam int hold_w = $clog2(reset_hold_cycles);
	localparam int init_w = $clog2(init_len);
	localparam int row_w  = $clog2(lcd_rows);
	localparam int col_w  = $clog2(lcd_cols);

	typedef enum logic [3:0] {
		st_hold,
		st_poll_setup,
		st_poll_start,
		st_poll_read,
		st_wr_setup,
		st_wr_start,
		st_wr_lo,
		st_wr_hi,
		st_idle
	} state_t;

	// which kind of item gets written next
	typedef enum logic [1:0] {
		ph_init,
		ph_addr,
		ph_char
	} phase_t;

	state_t                state;
	phase_t                phase;
	logic [hold_w-1:0]     hold_cnt;
	logic [init_w-1:0]     init_idx;
	logic [row_w-1:0]      row;
	logic [col_w-1:0]      col;
	logic [addr_bits-1:0]  char_idx;
	// byte of the write in flight
	logic [7:0]            wr_byte;
	logic [7:0]            item_byte;
	logic                  item_rs;

	// start byte, sent low bit first: sync ones, rw, rs, then a zero
	function automatic logic [bus_bits-1:0] start_byte(input logic rw, input logic rs);
		return {1'b0, rs, rw, sync_bits};
	endfunction

	assign busy     = (state != st_idle);
	assign lcd_rst  = (state != st_hold);
	// text memory follows the character counter
	assign mem_addr = char_idx;

	// ------------------------------
	// next item to write
	// ------------------------------
	always_comb begin
		case (phase)
			ph_init: begin
				item_byte = init_cmds[init_idx];
				item_rs   = 1'b0;
			end
			ph_addr: begin
				item_byte = cmd_set_ddram | line_addr[row];
				item_rs   = 1'b0;
			end
			default: begin
				// rd_data settled long before, a whole poll lies in between
				item_byte = mem_word;
				item_rs   = 1'b1;
			end
		endcase
	end

	always_ff @(posedge clk27) begin
		if (state == st_wr_setup && bus_ready) begin
			wr_byte <= item_byte;
		end
	end

	// ------------------------------
	// main FSM
	// ------------------------------
	always_ff @(posedge clk27 or negedge rst_n) begin
		if (!rst_n) begin
			state        <= st_hold;
			phase        <= ph_init;
			hold_cnt     <= '0;
			init_idx     <= '0;
			row          <= '0;
			col          <= '0;
			char_idx     <= '0;
			bus_enable   <= 1'b0;
			bus_data_out <= '0;
		end else begin
			case (state)
				st_hold: begin
					if (hold_cnt == hold_w'(reset_hold_cycles - 1)) begin
						state <= st_poll_setup;
					end else begin
						hold_cnt <= hold_cnt + 1'b1;
					end
				end
				// busy poll, read start byte plus one read word
				st_poll_setup: begin
					if (bus_ready) begin
						bus_enable   <= 1'b1;
						bus_data_out <= start_byte(1'b1, 1'b0);
						state        <= st_poll_start;
					end
				end
				st_poll_start: begin
					if (bus_next) begin
						// dummy word, lcd drives sda_i meanwhile
						bus_data_out <= '0;
						state        <= st_poll_read;
					end
				end
				st_poll_read: begin
					if (bus_next) begin
						bus_enable <= 1'b0;
						// bit 7 is the busy flag, poll again while set
						state      <= bus_data_in[7] ? st_poll_setup : st_wr_setup;
					end
				end
				// write, start byte then low and high nibble
				st_wr_setup: begin
					if (bus_ready) begin
						bus_enable   <= 1'b1;
						bus_data_out <= start_byte(1'b0, item_rs);
						state        <= st_wr_start;
					end
				end
				st_wr_start: begin
					if (bus_next) begin
						bus_data_out <= {4'h0, wr_byte[3:0]};
						state        <= st_wr_lo;
					end
				end
				st_wr_lo: begin
					if (bus_next) begin
						bus_data_out <= {4'h0, wr_byte[7:4]};
						state        <= st_wr_hi;
					end
				end
				st_wr_hi: begin
					if (bus_next) begin
						bus_enable <= 1'b0;
						state      <= st_poll_setup;
						case (phase)
							ph_init: begin
								if (init_idx == init_w'(init_len - 1)) begin
									phase <= ph_addr;
									row   <= '0;
								end else begin
									init_idx <= init_idx + 1'b1;
								end
							end
							ph_addr: begin
								phase <= ph_char;
								col   <= '0;
							end
							default: begin
								char_idx <= char_idx + 1'b1;
								if (col != col_w'(lcd_cols - 1)) begin
									col <= col + 1'b1;
								end else if (row != row_w'(lcd_rows - 1)) begin
									// next row starts with its address
									row   <= row + 1'b1;
									phase <= ph_addr;
								end else begin
									state <= st_idle;
								end
							end
						endcase
					end
				end
				// update restarts the full list, init included
				st_idle: begin
					if (update) begin
						phase    <= ph_init;
						init_idx <= '0;
						row      <= '0;
						col      <= '0;
						char_idx <= '0;
						state    <= st_poll_setup;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

endmodule

/* src/text_ram.sv */
// character memory of the display, user write port and registered read port for the controller
module text_ram (
	input  logic                          clk27,
	input  logic                          wr_en,
	input  logic [lcd_pkg::addr_bits-1:0] wr_addr,
	input  logic [7:0]                    wr_data,
	input  logic [lcd_pkg::addr_bits-1:0] rd_addr,
	output logic [7:0]                    rd_data
);
	import lcd_pkg::*;

	// one byte per character cell, row by row
	logic [7:0] mem [lcd_size];

	logic wr_hit;
	logic rd_hit;

	// addresses past the last cell
	assign wr_hit = (wr_addr < addr_bits'(lcd_size));
	assign rd_hit = (rd_addr < addr_bits'(lcd_size));

	// ------------------------------
	// write and read ports
	// ------------------------------
	always_ff @(posedge clk27) begin
		if (wr_en && wr_hit) begin
			mem[wr_addr] <= wr_data;
		end
		// read before write on the same address
		if (rd_hit) begin
			rd_data <= mem[rd_addr];
		end else begin
			// blank outside the text area
			rd_data <= 8'h20;
		end
	end

endmodule

/* src/serial_master.sv */
// bit-serial bus engine, generates scl and shifts words out and in low bit first
module serial_master (
	input  logic                         clk27,
	input  logic                         rst_n,
	input  logic                         enable,
	input  logic [lcd_pkg::bus_bits-1:0] data_out,
	output logic                         ready,
	output logic                         next_word,
	output logic [lcd_pkg::bus_bits-1:0] data_in,
	output logic                         scl,
	output logic                         sda_o,
	input  logic                         sda_i
);
	import lcd_pkg::*;

	localparam int div_w = $clog2(clk_div);
	localparam int bit_w = $clog2(bus_bits);

	// burst in progress
	logic                active;
	// main clocks within the current half bus period
	logic [div_w-1:0]    div_cnt;
	// bit position within the current word
	logic [bit_w-1:0]    bit_cnt;
	logic [bus_bits-1:0] tx_sr;
	logic [bus_bits-1:0] rx_sr;

	logic half_end;
	logic last_bit;
	logic start_burst;
	logic bit_end;
	logic load_word;
	logic shift_bit;
	logic sample;

	// ------------------------------
	// timing strobes
	// ------------------------------
	assign half_end    = (div_cnt == div_w'(clk_div - 1));
	assign last_bit    = (bit_cnt == bit_w'(bus_bits - 1));
	// idle engine picks up a word as soon as enable shows up
	assign start_burst = !active && enable;
	// end of a high half is the end of a bit
	assign bit_end     = active && half_end && scl;
	// next word of the burst follows the last bit without a gap
	assign load_word   = start_burst || (bit_end && last_bit && enable);
	assign shift_bit   = bit_end && !last_bit;
	// rising scl edge, lcd and engine both sample here
	assign sample      = active && half_end && !scl;

	// handshake
	assign ready = !active;
	// two cycles before the word boundary
	// so a registered controller has its next word ready in time
	// (needs clk_div of 3 or more)
	assign next_word = active && scl && last_bit && (div_cnt == div_w'(clk_div - 2));
	assign data_in = rx_sr;

	// data only driven while shifting
	assign sda_o = active ? tx_sr[0] : 1'b0;

	// ------------------------------
	// bus clock and bit counting
	// ------------------------------
	always_ff @(posedge clk27 or negedge rst_n) begin
		if (!rst_n) begin
			active  <= 1'b0;
			div_cnt <= '0;
			bit_cnt <= '0;
			scl     <= 1'b1;
		end else if (start_burst) begin
			// falling edge together with the first data bit
			active  <= 1'b1;
			div_cnt <= '0;
			bit_cnt <= '0;
			scl     <= 1'b0;
		end else if (active) begin
			if (!half_end) begin
				div_cnt <= div_cnt + 1'b1;
			end else begin
				div_cnt <= '0;
				if (!scl) begin
					scl <= 1'b1;
				end else if (!last_bit) begin
					bit_cnt <= bit_cnt + 1'b1;
					scl     <= 1'b0;
				end else if (enable) begin
					// burst continues with a fresh word
					bit_cnt <= '0;
					scl     <= 1'b0;
				end else begin
					// scl stays high, back to idle
					active <= 1'b0;
				end
			end
		end
	end

	// ------------------------------
	// shift registers
	// ------------------------------
	always_ff @(posedge clk27) begin
		if (load_word) begin
			tx_sr <= data_out;
		end else if (shift_bit) begin
			tx_sr <= tx_sr >> 1;
		end
		// low bit arrives first, ends up in bit 0
		if (sample) begin
			rx_sr <= {sda_i, rx_sr[bus_bits-1:1]};
		end
	end

endmodule

/* src/lcd_pkg.sv */
// shared constants for the 3-wire text lcd driver, imported by the rtl and the testbench
package lcd_pkg;

	// ------------------------------
	// clocks
	// ------------------------------
	localparam int main_clk_hz   = 27_000_000;
	localparam int serial_clk_hz = 1_000_000;

	// main clock cycles per half bus clock, rounds down (13)
	localparam int clk_div = main_clk_hz / (2 * serial_clk_hz);

	// ------------------------------
	// bus and display geometry
	// ------------------------------
	localparam int bus_bits  = 8;
	localparam int lcd_cols  = 20;
	localparam int lcd_rows  = 4;
	localparam int lcd_size  = lcd_cols * lcd_rows;
	localparam int addr_bits = 7;

	// lcd reset held low for 100 us after power up
	localparam int reset_hold_cycles = main_clk_hz / 10_000;

	// ------------------------------
	// lcd commands
	// ------------------------------
	// 8 bit interface, 2 line addressing
	localparam logic [7:0] cmd_function_set = 8'h38;
	// display on, cursor and blink off
	localparam logic [7:0] cmd_display_on   = 8'h0c;
	localparam logic [7:0] cmd_clear        = 8'h01;
	// increment address, no shift
	localparam logic [7:0] cmd_entry_mode   = 8'h06;
	// or-ed with the ddram address
	localparam logic [7:0] cmd_set_ddram    = 8'h80;

	// init list, index 0 goes out first
	localparam int init_len = 4;
	localparam logic [0:init_len-1][7:0] init_cmds = {
		cmd_function_set, cmd_display_on, cmd_clear, cmd_entry_mode
	};

	// ddram start of each row
	localparam logic [0:lcd_rows-1][7:0] line_addr = {8'h00, 8'h20, 8'h40, 8'h60};

	// first five bits of every start byte
	localparam logic [4:0] sync_bits = 5'b11111;

endpackage
